/* usbPkg.sv */
package usbPkg;

  //////////////////////////////////////////////////
  // Field widths fixed by the USB packet format
  //////////////////////////////////////////////////
  localparam int pidWidth = 8;
  localparam int addressWidth = 7;
  localparam int endpointWidth = 4;
  localparam int dataWidth = 64;
  localparam int fieldCountWidth = 7;
  localparam int crcWidth = 16;
  localparam int crc5Width = 5;
  localparam int crcCountWidth = 5;
  localparam int tokenFieldCount = 11;

  typedef enum logic [2:0] {tokenOut, tokenIn, handshakeAck, handshakeNak, data0} packetKind;
  typedef enum logic [1:0] {crcNone, crc5, crc16} crcMode;

  // PIDs, sent LSB first
  localparam logic [pidWidth-1:0] pidOut = 8'hE1;
  localparam logic [pidWidth-1:0] pidIn = 8'h69;
  localparam logic [pidWidth-1:0] pidAck = 8'hD2;
  localparam logic [pidWidth-1:0] pidNak = 8'h5A;
  localparam logic [pidWidth-1:0] pidData0 = 8'hC3;

  // Seven zeros then a one
  localparam logic [7:0] syncPattern = 8'b1000_0000;
  localparam int stuffLimit = 6;
  localparam int eopCycles = 2;

  // x^5+x^2+1 and x^16+x^15+x^2+1
  localparam logic [crc5Width-1:0] crc5Poly = 5'b0_0101;
  localparam logic [crcWidth-1:0] crc16Poly = 16'h8005;
  localparam logic [crcWidth-1:0] crcInit = 16'hFFFF;

  // Line states as {dp, dm}
  typedef enum logic [1:0] {lineSe0 = 2'b00, lineK = 2'b01, lineJ = 2'b10} lineState;

  typedef struct packed {
    packetKind kind;
    logic [addressWidth-1:0] address;
    logic [endpointWidth-1:0] endpoint;
    logic [dataWidth-1:0] data;
  } usbRequest;

  typedef struct packed {
    logic [pidWidth-1:0] pid;
    logic [dataWidth-1:0] fieldBits;
    logic [fieldCountWidth-1:0] fieldCount;
    crcMode mode;
  } txFrame;

  typedef struct packed {
    logic [pidWidth-1:0] pid;
    logic [dataWidth-1:0] fieldBits;
    logic [fieldCountWidth-1:0] fieldCount;
    logic [crcWidth-1:0] crcBits;
    logic [crcCountWidth-1:0] crcCount;
  } txPacket;

  typedef struct packed {
    logic driveEnable;
    logic dp;
    logic dm;
  } busLine;

endpackage : usbPkg

/* packetFramer.sv */
`timescale 1ns/1ps

module packetFramer (
  input  logic              clock,
  input  logic              reset_n,
  input  logic              requestValid,
  output logic              requestReady,
  input  usbPkg::usbRequest request,
  output logic              frameValid,
  input  logic              frameReady,
  output usbPkg::txFrame    frame
);
  import usbPkg::*;

  txFrame decoded;
  logic accept;

  // Register is free when empty or being drained this cycle
  assign requestReady = !frameValid || frameReady;
  assign accept = requestValid && requestReady;

  //////////////////////////////////////////////////
  // Kind to PID, field layout and CRC mode
  //////////////////////////////////////////////////
  always_comb begin
    decoded.pid = pidNak;
    decoded.fieldBits = '0;
    decoded.fieldCount = '0;
    decoded.mode = crcNone;
    case (request.kind)
      tokenOut: begin
        decoded.pid = pidOut;
        decoded.fieldBits[addressWidth-1:0] = request.address;
        decoded.fieldBits[addressWidth +: endpointWidth] = request.endpoint;
        decoded.fieldCount = fieldCountWidth'(tokenFieldCount);
        decoded.mode = crc5;
      end
      tokenIn: begin
        decoded.pid = pidIn;
        decoded.fieldBits[addressWidth-1:0] = request.address;
        decoded.fieldBits[addressWidth +: endpointWidth] = request.endpoint;
        decoded.fieldCount = fieldCountWidth'(tokenFieldCount);
        decoded.mode = crc5;
      end
      handshakeAck: begin
        decoded.pid = pidAck;
      end
      handshakeNak: begin
        decoded.pid = pidNak;
      end
      data0: begin
        decoded.pid = pidData0;
        decoded.fieldBits = request.data;
        decoded.fieldCount = fieldCountWidth'(dataWidth);
        decoded.mode = crc16;
      end
      default: begin
        decoded.pid = pidNak;
      end
    endcase
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      frameValid <= 1'b0;
    end else if (accept) begin
      frameValid <= 1'b1;
    end else if (frameReady) begin
      frameValid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      frame <= decoded;
    end
  end

endmodule : packetFramer

/* crcGenerator.sv */
`timescale 1ns/1ps

module crcGenerator (
  input  logic            clock,
  input  logic            reset_n,
  input  logic            frameValid,
  output logic            frameReady,
  input  usbPkg::txFrame  frame,
  output logic            packetValid,
  input  logic            packetReady,
  output usbPkg::txPacket packet
);
  import usbPkg::*;

  typedef enum logic [1:0] {empty, shifting, full} crcState;

  crcState state;
  crcMode modeReg;
  logic [fieldCountWidth-1:0] bitIndex;
  logic [crcWidth-1:0] crcReg;
  logic [crcWidth-1:0] crcNext;
  logic [crcWidth-1:0] crcSend;
  logic inBit;
  logic feedback;
  logic lastBit;
  logic accept;

  assign frameReady = (state == empty);
  assign packetValid = (state == full);
  assign accept = frameValid && frameReady;

  assign inBit = packet.fieldBits[bitIndex[5:0]];
  assign lastBit = (bitIndex == packet.fieldCount - 1'b1);

  //////////////////////////////////////////////////
  // Serial LFSR, one field bit per cycle
  //////////////////////////////////////////////////
  always_comb begin
    if (modeReg == crc16) begin
      feedback = crcReg[crcWidth-1] ^ inBit;
      crcNext = {crcReg[crcWidth-2:0], 1'b0} ^ (feedback ? crc16Poly : '0);
    end else begin
      feedback = crcReg[crc5Width-1] ^ inBit;
      crcNext = '0;
      crcNext[crc5Width-1:0] = {crcReg[crc5Width-2:0], 1'b0} ^ (feedback ? crc5Poly : '0);
    end
  end

  // Highest remainder bit goes out first, complemented
  always_comb begin
    crcSend = '0;
    if (modeReg == crc16) begin
      for (int i = 0; i < crcWidth; i++) begin
        crcSend[i] = ~crcNext[crcWidth-1-i];
      end
    end else begin
      for (int i = 0; i < crc5Width; i++) begin
        crcSend[i] = ~crcNext[crc5Width-1-i];
      end
    end
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state <= empty;
      bitIndex <= '0;
    end else begin
      case (state)
        empty: begin
          if (accept) begin
            bitIndex <= '0;
            if (frame.fieldCount == '0) begin
              state <= full;
            end else begin
              state <= shifting;
            end
          end
        end
        shifting: begin
          bitIndex <= bitIndex + 1'b1;
          if (lastBit) begin
            state <= full;
          end
        end
        full: begin
          if (packetReady) begin
            state <= empty;
          end
        end
        default: state <= empty;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      packet.pid <= frame.pid;
      packet.fieldBits <= frame.fieldBits;
      packet.fieldCount <= frame.fieldCount;
      packet.crcBits <= '0;
      packet.crcCount <= '0;
      modeReg <= frame.mode;
      crcReg <= crcInit;
    end else if (state == shifting) begin
      crcReg <= crcNext;
      if (lastBit) begin
        packet.crcBits <= crcSend;
        if (modeReg == crc16) begin
          packet.crcCount <= crcCountWidth'(crcWidth);
        end else begin
          packet.crcCount <= crcCountWidth'(crc5Width);
        end
      end
    end
  end

endmodule : crcGenerator

/* lineEncoder.sv */
`timescale 1ns/1ps

module lineEncoder (
  input  logic            clock,
  input  logic            reset_n,
  input  logic            packetValid,
  output logic            packetReady,
  input  usbPkg::txPacket packet,
  output usbPkg::busLine  line,
  output logic            packetDone
);
  import usbPkg::*;

  typedef enum logic [2:0] {idle, sync, pid, fields, crc, eop, finalJ} encoderState;

  encoderState state;
  encoderState nextSection;
  txPacket pkt;
  logic [fieldCountWidth-1:0] bitIndex;
  logic [fieldCountWidth-1:0] lastIndex;
  logic [2:0] onesCount;
  logic [1:0] eopCount;
  logic level;
  logic accept;
  logic stuffNow;
  logic dataState;
  logic sending;
  logic sectionBit;
  logic sendBit;
  logic nrziOut;
  lineState lineValue;

  assign packetReady = (state == idle);
  assign accept = packetValid && packetReady;

  assign dataState = (state == sync) || (state == pid) || (state == fields) || (state == crc);
  assign stuffNow = (onesCount == 3'(stuffLimit));
  // A pending stuffed zero may still go out at the start of eop
  assign sending = dataState || ((state == eop) && stuffNow);
  assign sendBit = stuffNow ? 1'b0 : sectionBit;
  // level is 1 for J, a zero toggles it
  assign nrziOut = sendBit ? level : ~level;

  //////////////////////////////////////////////////
  // Bit source and length of each section
  //////////////////////////////////////////////////
  always_comb begin
    sectionBit = 1'b0;
    lastIndex = fieldCountWidth'(pidWidth - 1);
    case (state)
      sync: sectionBit = syncPattern[bitIndex[2:0]];
      pid: sectionBit = pkt.pid[bitIndex[2:0]];
      fields: begin
        sectionBit = pkt.fieldBits[bitIndex[5:0]];
        lastIndex = pkt.fieldCount - 1'b1;
      end
      crc: begin
        sectionBit = pkt.crcBits[bitIndex[3:0]];
        lastIndex = fieldCountWidth'(pkt.crcCount) - 1'b1;
      end
      default: sectionBit = 1'b0;
    endcase
  end

  always_comb begin
    nextSection = eop;
    if (state == sync) begin
      nextSection = pid;
    end else if ((state == pid) && (pkt.fieldCount != '0)) begin
      nextSection = fields;
    end else if (((state == pid) || (state == fields)) && (pkt.crcCount != '0)) begin
      nextSection = crc;
    end
  end

  always_comb begin
    if ((state == eop) && !stuffNow) begin
      lineValue = lineSe0;
    end else if (sending && !nrziOut) begin
      lineValue = lineK;
    end else begin
      lineValue = lineJ;
    end
  end

  assign line.driveEnable = (state != idle);
  assign {line.dp, line.dm} = lineValue;

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state <= idle;
      bitIndex <= '0;
      onesCount <= '0;
      eopCount <= '0;
      level <= 1'b1;
      packetDone <= 1'b0;
    end else begin
      packetDone <= 1'b0;
      if (sending) begin
        level <= nrziOut;
        onesCount <= sendBit ? onesCount + 1'b1 : '0;
      end
      case (state)
        idle: begin
          if (accept) begin
            state <= sync;
            bitIndex <= '0;
            onesCount <= '0;
            eopCount <= '0;
            level <= 1'b1;
          end
        end
        sync, pid, fields, crc: begin
          // Stuffed zero holds the index
          if (!stuffNow) begin
            if (bitIndex == lastIndex) begin
              bitIndex <= '0;
              state <= nextSection;
            end else begin
              bitIndex <= bitIndex + 1'b1;
            end
          end
        end
        eop: begin
          if (!stuffNow) begin
            if (eopCount == 2'(eopCycles - 1)) begin
              state <= finalJ;
            end else begin
              eopCount <= eopCount + 1'b1;
            end
          end
        end
        finalJ: begin
          state <= idle;
          packetDone <= 1'b1;
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      pkt <= packet;
    end
  end

endmodule : lineEncoder

/* usbTxTop.sv */
`timescale 1ns/1ps

module usbTxTop (
  input  logic              clock,
  input  logic              reset_n,
  input  logic              requestValid,
  output logic              requestReady,
  input  usbPkg::usbRequest request,
  output usbPkg::busLine    line,
  output logic              packetDone
);
  import usbPkg::*;

  logic frameValid;
  logic frameReady;
  txFrame frame;
  logic packetValid;
  logic packetReady;
  txPacket packet;

  //////////////////////////////////////////////////
  // Decode, CRC, line coding
  //////////////////////////////////////////////////
  packetFramer u_packetFramer (
    .clock        (clock),
    .reset_n      (reset_n),
    .requestValid (requestValid),
    .requestReady (requestReady),
    .request      (request),
    .frameValid   (frameValid),
    .frameReady   (frameReady),
    .frame        (frame)
  );

  crcGenerator u_crcGenerator (
    .clock       (clock),
    .reset_n     (reset_n),
    .frameValid  (frameValid),
    .frameReady  (frameReady),
    .frame       (frame),
    .packetValid (packetValid),
    .packetReady (packetReady),
    .packet      (packet)
  );

  lineEncoder u_lineEncoder (
    .clock       (clock),
    .reset_n     (reset_n),
    .packetValid (packetValid),
    .packetReady (packetReady),
    .packet      (packet),
    .line        (line),
    .packetDone  (packetDone)
  );

endmodule : usbTxTop

/* usbTx_asserts.sv */
`timescale 1ns/1ps

module usbTxAsserts (
  input logic              clock,
  input logic              reset_n,
  input logic              requestValid,
  input logic              requestReady,
  input usbPkg::usbRequest request,
  input usbPkg::busLine    line,
  input logic              packetDone
);

  // No SE1 on the bus
  noSe1: assert property (@(posedge clock) disable iff (!reset_n)
    line.driveEnable |-> !(line.dp && line.dm))
    else $error("dp and dm both high while driven");

  donePulse: assert property (@(posedge clock) disable iff (!reset_n)
    packetDone |=> !packetDone)
    else $error("packetDone longer than one cycle");

  requestHeld: assert property (@(posedge clock) disable iff (!reset_n)
    (requestValid && !requestReady) |=> $stable(request))
    else $error("request changed while waiting for ready");

  idleAfterReset: assert property (@(posedge clock)
    $rose(reset_n) |-> !line.driveEnable)
    else $error("driveEnable high right after reset");

endmodule : usbTxAsserts

bind usbTxTop usbTxAsserts u_usbTxAsserts (
  .clock        (clock),
  .reset_n      (reset_n),
  .requestValid (requestValid),
  .requestReady (requestReady),
  .request      (request),
  .line         (line),
  .packetDone   (packetDone)
);

/* usbTxMonitor.sv */
`timescale 1ns/1ps

module usbTxMonitor (
  input  logic              clock,
  input  logic              reset_n,
  input  logic              requestValid,
  input  logic              requestReady,
  input  usbPkg::usbRequest request,
  input  usbPkg::busLine    line,
  input  logic              packetDone,
  input  logic              finishRun,
  output int                errorCount,
  output int                acceptedCount,
  output int                doneCount
);
  import usbPkg::*;

  usbRequest pending[$];
  logic [127:0] rxBits;
  logic [6:0] rxCount;
  logic [127:0] expBits;
  logic [6:0] expCount;
  logic prevLevel;
  logic rxBit;
  logic afterReset;
  logic endChecked;
  int onesRun;
  int se0Cycles;
  int jCycles;

  task automatic flagMismatch(input string msg);
    errorCount++;
    $display("FAILED at time %0d ns: %s", $time, msg);
  endtask

  task automatic addExpected(input logic b);
    expBits[expCount] = b;
    expCount = expCount + 7'd1;
  endtask

  task automatic clearReceiver();
    rxBits = '0;
    rxCount = '0;
    prevLevel = 1'b1;
    onesRun = 0;
    se0Cycles = 0;
    jCycles = 0;
  endtask

  //////////////////////////////////////////////////
  // Reference stream before stuffing
  //////////////////////////////////////////////////
  task automatic buildExpected(input usbRequest req);
    logic [7:0] pidValue;
    logic [63:0] work;
    logic [15:0] crcReg;
    int fieldLen;
    int crcLen;
    expBits = '0;
    expCount = '0;
    work = '0;
    fieldLen = 0;
    crcLen = 0;
    case (req.kind)
      tokenOut: pidValue = 8'hE1;
      tokenIn: pidValue = 8'h69;
      handshakeAck: pidValue = 8'hD2;
      handshakeNak: pidValue = 8'h5A;
      default: pidValue = 8'hC3;
    endcase
    if (req.kind == tokenOut || req.kind == tokenIn) begin
      work[10:0] = {req.endpoint, req.address};
      fieldLen = 11;
      crcLen = 5;
    end else if (req.kind == data0) begin
      work = req.data;
      fieldLen = 64;
      crcLen = 16;
    end
    for (int i = 0; i < 8; i++) begin
      addExpected(i == 7);
    end
    for (int i = 0; i < 8; i++) begin
      addExpected(pidValue[0]);
      pidValue = pidValue >> 1;
    end
    // CRC5 lives in the top five bits so both go out MSB first
    crcReg = 16'hFFFF;
    for (int i = 0; i < fieldLen; i++) begin
      addExpected(work[0]);
      if (crcLen == 16) begin
        crcReg = {crcReg[14:0], 1'b0} ^ ((crcReg[15] ^ work[0]) ? 16'h8005 : 16'h0000);
      end else begin
        crcReg[15:11] = {crcReg[14:11], 1'b0} ^ ((crcReg[15] ^ work[0]) ? 5'h05 : 5'h00);
      end
      work = work >> 1;
    end
    for (int i = 0; i < crcLen; i++) begin
      addExpected(~crcReg[15]);
      crcReg = crcReg << 1;
    end
  endtask

  always @(posedge clock) begin
    if (!reset_n) begin
      afterReset = 1'b1;
      endChecked = 1'b0;
      clearReceiver();
    end else begin
      if (afterReset && (line.driveEnable || packetDone || !requestReady)) begin
        flagMismatch("outputs not at their reset values");
      end
      afterReset = 1'b0;
      if (requestValid && requestReady) begin
        pending.push_back(request);
        acceptedCount++;
      end
      if (line.driveEnable) begin
        if (line.dp && line.dm) begin
          flagMismatch("dp and dm both high while driven");
        end else if (!line.dp && !line.dm) begin
          se0Cycles++;
        end else if (se0Cycles > 0) begin
          jCycles++;
          if (!line.dp) begin
            flagMismatch("K after SE0 instead of J");
          end
        end else begin
          // NRZI, an unchanged level is a one
          rxBit = (line.dp == prevLevel);
          prevLevel = line.dp;
          if (onesRun == 6) begin
            if (rxBit) begin
              flagMismatch("missing stuffed zero after six ones");
            end
            onesRun = 0;
          end else begin
            if (rxCount != 7'h7F) begin
              rxBits[rxCount] = rxBit;
              rxCount = rxCount + 7'd1;
            end
            onesRun = rxBit ? onesRun + 1 : 0;
          end
        end
      end
      if (packetDone) begin
        doneCount++;
        if (pending.size() == 0) begin
          flagMismatch("packet on the line without an accepted request");
        end else begin
          buildExpected(pending.pop_front());
          if (rxCount != expCount || rxBits != expBits) begin
            flagMismatch($sformatf("line bits %0d:%h expected %0d:%h",
                                   rxCount, rxBits, expCount, expBits));
          end
          if (se0Cycles != 2 || jCycles != 1) begin
            flagMismatch($sformatf("end of packet %0d SE0 and %0d J", se0Cycles, jCycles));
          end
        end
        clearReceiver();
      end
      if (finishRun && !endChecked) begin
        endChecked = 1'b1;
        if (pending.size() != 0 || doneCount != acceptedCount) begin
          flagMismatch($sformatf("%0d requests accepted but %0d packets done",
                                 acceptedCount, doneCount));
        end
      end
    end
  end

endmodule : usbTxMonitor

/* usbTxTb.sv */
`timescale 1ns/1ps

module usbTxTb;
  import usbPkg::*;

  localparam int clockPeriod = 40;
  localparam int readyTimeout = 500;
  localparam int drainTimeout = 3000;
  localparam int numEntries = 14;

  typedef struct packed {
    packetKind kind;
    logic [6:0] address;
    logic [3:0] endpoint;
    logic [63:0] data;
    logic randomData;
    logic [3:0] gap;
  } stimEntry;

  logic clock;
  logic reset_n;
  logic requestValid;
  logic requestReady;
  usbRequest request;
  busLine line;
  logic packetDone;
  logic finishRun;
  int errorCount;
  int acceptedCount;
  int doneCount;
  int timeoutCount;
  logic [31:0] rngState;
  stimEntry stimTable [numEntries];

  usbTxTop u_usbTxTop (
    .clock        (clock),
    .reset_n      (reset_n),
    .requestValid (requestValid),
    .requestReady (requestReady),
    .request      (request),
    .line         (line),
    .packetDone   (packetDone)
  );

  usbTxMonitor u_usbTxMonitor (
    .clock         (clock),
    .reset_n       (reset_n),
    .requestValid  (requestValid),
    .requestReady  (requestReady),
    .request       (request),
    .line          (line),
    .packetDone    (packetDone),
    .finishRun     (finishRun),
    .errorCount    (errorCount),
    .acceptedCount (acceptedCount),
    .doneCount     (doneCount)
  );

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  function automatic stimEntry makeEntry(packetKind kind, logic [6:0] address,
      logic [3:0] endpoint, logic [63:0] data, logic randomData, logic [3:0] gap);
    stimEntry e;
    e.kind = kind;
    e.address = address;
    e.endpoint = endpoint;
    e.data = data;
    e.randomData = randomData;
    e.gap = gap;
    return e;
  endfunction

  //////////////////////////////////////////////////
  // Stimulus table, gap 0 means back to back
  //////////////////////////////////////////////////
  task automatic loadTable();
    stimTable[0] = makeEntry(handshakeAck, 7'h00, 4'h0, 64'h0, 1'b0, 4'd2);
    stimTable[1] = makeEntry(handshakeNak, 7'h00, 4'h0, 64'h0, 1'b0, 4'd0);
    stimTable[2] = makeEntry(tokenOut, 7'h00, 4'h0, 64'h0, 1'b0, 4'd0);
    stimTable[3] = makeEntry(tokenIn, 7'h15, 4'hE, 64'h0, 1'b0, 4'd0);
    stimTable[4] = makeEntry(tokenOut, 7'h7F, 4'hF, 64'h0, 1'b0, 4'd3);
    stimTable[5] = makeEntry(data0, 7'h00, 4'h0, 64'h0, 1'b1, 4'd0);
    stimTable[6] = makeEntry(data0, 7'h00, 4'h0, {64{1'b1}}, 1'b0, 4'd0);
    stimTable[7] = makeEntry(tokenIn, 7'h3A, 4'h1, 64'h0, 1'b0, 4'd0);
    stimTable[8] = makeEntry(data0, 7'h00, 4'h0, 64'h0, 1'b1, 4'd5);
    stimTable[9] = makeEntry(handshakeAck, 7'h00, 4'h0, 64'h0, 1'b0, 4'd0);
    stimTable[10] = makeEntry(data0, 7'h00, 4'h0, 64'h0, 1'b0, 4'd0);
    stimTable[11] = makeEntry(handshakeNak, 7'h00, 4'h0, 64'h0, 1'b0, 4'd1);
    stimTable[12] = makeEntry(data0, 7'h00, 4'h0, 64'h0, 1'b1, 4'd0);
    stimTable[13] = makeEntry(tokenOut, 7'h01, 4'h8, 64'h0, 1'b0, 4'd0);
  endtask

  task automatic applyEntry(input int index);
    stimEntry e;
    usbRequest req;
    int waitCycles;
    logic taken;
    e = stimTable[index];
    req.kind = e.kind;
    req.address = e.address;
    req.endpoint = e.endpoint;
    req.data = e.data;
    if (e.randomData) begin
      req.data[63:32] = nextRandom();
      req.data[31:0] = nextRandom();
    end
    if (e.gap != 4'd0) begin
      requestValid <= 1'b0;
      repeat (e.gap) @(posedge clock);
    end
    requestValid <= 1'b1;
    request <= req;
    taken = 1'b0;
    waitCycles = 0;
    // Ready comes from registers, settled by the falling edge
    while (!taken && waitCycles < readyTimeout) begin
      @(negedge clock);
      taken = requestReady;
      @(posedge clock);
      waitCycles++;
    end
    if (!taken) begin
      timeoutCount++;
      requestValid <= 1'b0;
      $display("Timeout: request %0d was not accepted within %0d cycles", index, readyTimeout);
    end
  endtask

  task automatic waitForDrain();
    int waitCycles;
    waitCycles = 0;
    while (doneCount < numEntries && waitCycles < drainTimeout) begin
      @(negedge clock);
      waitCycles++;
    end
    if (doneCount < numEntries) begin
      timeoutCount++;
      $display("Timeout: only %0d of %0d packets finished on the line", doneCount, numEntries);
    end
  endtask

  initial begin
    reset_n = 1'b0;
    requestValid = 1'b0;
    request = '0;
    finishRun = 1'b0;
    timeoutCount = 0;
    rngState = 32'h50e0_13f7;
    loadTable();
    repeat (2) @(posedge clock);
    reset_n <= 1'b1;
    @(posedge clock);
    for (int i = 0; i < numEntries; i++) begin
      if (timeoutCount == 0) begin
        applyEntry(i);
      end
    end
    requestValid <= 1'b0;
    if (timeoutCount == 0) begin
      waitForDrain();
    end
    finishRun <= 1'b1;
    repeat (3) @(posedge clock);
    $display("usbTx run: %0d accepted, %0d sent, %0d errors, %0d timeouts",
             acceptedCount, doneCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule : usbTxTb

/* usbTx.f */
usbPkg.sv
packetFramer.sv
crcGenerator.sv
lineEncoder.sv
usbTxTop.sv
usbTx_asserts.sv
usbTxMonitor.sv
usbTxTb.sv

/* Makefile */
# Verilator simulation of the usbTx transmit path

VERILATOR ?= verilator
TOP ?= usbTxTb
FILELIST ?= usbTx.f
OBJDIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= TEST RESULT: PASS
VFLAGS ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR LOG PASS_TEXT VFLAGS"

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

test: $(OBJDIR)/V$(TOP)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "usbTx simulation passed"; \
	else \
		echo "usbTx simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
